// ==== Bender.yml ====
package:
  name: s16_game

sources:
  - files:
      - source/s16_pkg.sv
      - source/s16_bus_decode.sv
      - source/s16_bus_exec.sv
      - source/s16_gfx_bank.sv
      - source/s16_result.sv
      - source/s16_game.sv
  - target: test
    files:
      - bench/s16_game_sva.sv
      - bench/s16_game_tb.sv

// ==== bench/s16_game_sva.sv ====
// Bus pipeline concurrent checks
`timescale 1ns/100ps
`default_nettype none

module s16_game_sva (
    input logic                  clk,
    input logic                  rst,
    input logic                  bus_stb,
    input s16_pkg::s16_bus_req_t bus_req,
    input logic [7:0]            st_addr,
    input logic                  rd_valid,
    input logic                  snd_irqn,
    input logic                  flip,
    input logic                  video_en,
    input logic [7:0]            st_dout,
    input logic                  scr1_cs_g,
    input logic                  scr2_cs_g
);

    logic       rd_stb;
    logic [7:0] stb_cnt;
    int         err_cnt = 0;

    assign rd_stb = bus_stb && bus_req.rnw;

    // Strobes seen on the bus, wraps at 256
    always_ff @(posedge clk) begin
        if (rst) begin
            stb_cnt <= '0;
        end else if (bus_stb) begin
            stb_cnt <= stb_cnt + 8'd1;
        end
    end

    a_rd_latency: assert property (@(posedge clk) disable iff (rst)
        $past(rd_stb, 3) |-> rd_valid)
        else begin
            err_cnt++;
            $error("read strobe not answered by rd_valid 3 cycles later");
        end

    a_rd_cause: assert property (@(posedge clk) disable iff (rst)
        rd_valid |-> $past(rd_stb, 3))
        else begin
            err_cnt++;
            $error("rd_valid without a read strobe 3 cycles earlier");
        end

    a_reset_vals: assert property (@(posedge clk)
        $past(rst) |-> (snd_irqn && !rd_valid && !flip && !video_en
                        && !scr1_cs_g && !scr2_cs_g && st_dout == 8'h00))
        else begin
            err_cnt++;
            $error("outputs not at reset values while in reset");
        end

    // Counter lags the strobe by decode plus status register
    a_acc_count: assert property (@(posedge clk) disable iff (rst)
        ($past(st_addr) == 8'h03) |-> (st_dout == $past(stb_cnt, 2)))
        else begin
            err_cnt++;
            $error("status counter does not match strobe count");
        end

endmodule

`default_nettype wire

// ==== bench/s16_game_tb.sv ====
// S16 bus testbench
`timescale 1ns/100ps
`default_nettype none

module s16_game_tb;
    import s16_pkg::*;

    localparam int CHAR_AW = 10;
    localparam int PAL_AW  = 10;
    localparam int OBJ_AW  = 8;

    logic         clk;
    logic         rst;
    logic         bus_stb;
    s16_bus_req_t bus_req;
    logic         rd_valid;
    logic [15:0]  rd_data;
    logic         snd_ack;
    logic [7:0]   snd_latch;
    logic         snd_irqn;
    logic         flip;
    logic         video_en;
    logic [7:0]   st_addr;
    logic [7:0]   st_dout;
    logic         scr1_cs;
    logic         scr2_cs;
    logic [15:0]  scr1_addr;
    logic [15:0]  scr2_addr;
    logic         scr1_cs_g;
    logic         scr2_cs_g;
    logic [17:0]  scr1_adj;
    logic [17:0]  scr2_adj;

    // Reference model state
    logic [15:0]  char_m [2**CHAR_AW];
    logic [15:0]  pal_m [2**PAL_AW];
    logic [15:0]  obj_m [2**OBJ_AW];
    logic [3:0]   ctrl_m;
    logic [5:0]   bank_m;
    logic [7:0]   latch_m;
    logic [15:0]  exp_q [$];
    logic [15:0]  mon_exp;
    logic [31:0]  rng_state = 32'd55466;

    s16_game #(
        .CHAR_AW ( CHAR_AW ),
        .PAL_AW  ( PAL_AW  ),
        .OBJ_AW  ( OBJ_AW  )
    ) u_dut (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .bus_stb   ( bus_stb   ),
        .bus_req   ( bus_req   ),
        .rd_valid  ( rd_valid  ),
        .rd_data   ( rd_data   ),
        .snd_ack   ( snd_ack   ),
        .snd_latch ( snd_latch ),
        .snd_irqn  ( snd_irqn  ),
        .flip      ( flip      ),
        .video_en  ( video_en  ),
        .st_addr   ( st_addr   ),
        .st_dout   ( st_dout   ),
        .scr1_cs   ( scr1_cs   ),
        .scr2_cs   ( scr2_cs   ),
        .scr1_addr ( scr1_addr ),
        .scr2_addr ( scr2_addr ),
        .scr1_cs_g ( scr1_cs_g ),
        .scr2_cs_g ( scr2_cs_g ),
        .scr1_adj  ( scr1_adj  ),
        .scr2_adj  ( scr2_adj  )
    );

    bind s16_game s16_game_sva u_sva (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .bus_stb   ( bus_stb   ),
        .bus_req   ( bus_req   ),
        .st_addr   ( st_addr   ),
        .rd_valid  ( rd_valid  ),
        .snd_irqn  ( snd_irqn  ),
        .flip      ( flip      ),
        .video_en  ( video_en  ),
        .st_dout   ( st_dout   ),
        .scr1_cs_g ( scr1_cs_g ),
        .scr2_cs_g ( scr2_cs_g )
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic stop_fail();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic fail_text(input string what);
        $display("%s", what);
        stop_fail();
    endtask

    task automatic fail_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        $display("FAILED %s: got %h expected %h", name, got, exp);
        stop_fail();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else fail_value(name, got, exp);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int region_depth(input int r);
        case (r)
            0:       return 2**CHAR_AW;
            1:       return 2**PAL_AW;
            default: return 2**OBJ_AW;
        endcase
    endfunction

    // Low strobe bits enable their byte lane
    function automatic logic [15:0] merge_lanes(input logic [15:0] old,
                                                input logic [15:0] data,
                                                input logic [1:0] dsn);
        logic [15:0] res;
        res = old;
        if (!dsn[1]) begin
            res[15:8] = data[15:8];
        end
        if (!dsn[0]) begin
            res[7:0] = data[7:0];
        end
        return res;
    endfunction

    task automatic model_write(input logic [15:0] addr, input logic [15:0] data,
                               input logic [1:0] dsn);
        logic [12:0] ofs;
        ofs = addr[12:0];
        case (addr[15:13])
            3'd0: begin
                if (ofs < 2**CHAR_AW) begin
                    char_m[ofs] = merge_lanes(char_m[ofs], data, dsn);
                end
            end
            3'd1: begin
                if (ofs < 2**PAL_AW) begin
                    pal_m[ofs] = merge_lanes(pal_m[ofs], data, dsn);
                end
            end
            3'd2: begin
                if (ofs < 2**OBJ_AW) begin
                    obj_m[ofs] = merge_lanes(obj_m[ofs], data, dsn);
                end
            end
            3'd3: begin
                // I/O fields sit in the low byte lane
                if (!dsn[0] && ofs == 13'd0) begin
                    ctrl_m = data[3:0];
                end else if (!dsn[0] && ofs == 13'd1) begin
                    bank_m = data[5:0];
                end else if (!dsn[0] && ofs == 13'd2) begin
                    latch_m = data[7:0];
                end
            end
            default: begin
            end
        endcase
    endtask

    function automatic logic [15:0] model_read(input logic [15:0] addr);
        logic [12:0] ofs;
        ofs = addr[12:0];
        case (addr[15:13])
            3'd0: return (ofs < 2**CHAR_AW) ? char_m[ofs] : 16'hffff;
            3'd1: return (ofs < 2**PAL_AW) ? pal_m[ofs] : 16'hffff;
            3'd2: return (ofs < 2**OBJ_AW) ? obj_m[ofs] : 16'hffff;
            3'd3: begin
                case (ofs)
                    13'd0:   return {12'd0, ctrl_m};
                    13'd1:   return {10'd0, bank_m};
                    13'd2:   return {8'd0, latch_m};
                    default: return 16'hffff;
                endcase
            end
            default: return 16'hffff;
        endcase
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // One strobe cycle with the model updated in issue order
    task automatic bus_access(input logic [15:0] addr, input logic [15:0] data,
                              input logic [1:0] dsn, input logic rnw);
        bus_stb      = 1'b1;
        bus_req.addr = addr;
        bus_req.data = data;
        bus_req.dsn  = dsn;
        bus_req.rnw  = rnw;
        if (rnw) begin
            exp_q.push_back(model_read(addr));
        end else begin
            model_write(addr, data, dsn);
        end
        idle_cycles(1);
        bus_stb = 1'b0;
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [15:0] data,
                             input logic [1:0] dsn);
        bus_access(addr, data, dsn, 1'b0);
    endtask

    task automatic bus_read(input logic [15:0] addr);
        bus_access(addr, 16'h0000, 2'b00, 1'b1);
    endtask

    task automatic wait_reads_done();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            idle_cycles(1);
            n++;
        end
        if (exp_q.size() != 0) begin
            fail_text("timeout waiting for pending read data");
        end
    endtask

    task automatic wait_irq_release();
        int n;
        n = 0;
        while (!snd_irqn && n < 8) begin
            idle_cycles(1);
            n++;
        end
        if (!snd_irqn) begin
            fail_text("timeout waiting for snd_irqn to return high after snd_ack");
        end
    endtask

    // Read data checked on the falling edge
    always @(negedge clk) begin
        if (!rst && rd_valid) begin
            if (exp_q.size() == 0) begin
                fail_text("rd_valid arrived with no read pending");
            end else begin
                mon_exp = exp_q.pop_front();
                check_value("rd_data", rd_data, mon_exp);
            end
        end
    end

    always @(negedge clk) begin
        if (u_dut.u_sva.err_cnt != 0) begin
            fail_text("a concurrent assertion on the DUT failed");
        end
    end

    initial begin
        logic [15:0] addrs [8];
        logic [15:0] d;
        logic [15:0] a1;
        logic [15:0] a2;
        logic        ve;

        rst       = 1'b1;
        bus_stb   = 1'b0;
        bus_req   = '0;
        snd_ack   = 1'b0;
        st_addr   = 8'h03;
        scr1_cs   = 1'b0;
        scr2_cs   = 1'b0;
        scr1_addr = '0;
        scr2_addr = '0;
        ctrl_m    = '0;
        bank_m    = '0;
        latch_m   = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        idle_cycles(1);

        // Fill the RAMs, merge byte lanes and read back to back
        for (int r = 0; r < 3; r++) begin
            for (int i = 0; i < 8; i++) begin
                addrs[i] = {3'(r), 13'(next_random() % 32'(region_depth(r)))};
                bus_write(addrs[i], 16'(next_random()), 2'b00);
            end
            for (int i = 0; i < 8; i++) begin
                bus_write(addrs[i], 16'(next_random()), 2'(next_random()));
            end
            for (int i = 0; i < 8; i++) begin
                bus_read(addrs[i]);
            end
            for (int i = 0; i < 8; i++) begin
                bus_write(addrs[i], 16'(next_random()), 2'(next_random()));
                bus_read(addrs[i]);
            end
            wait_reads_done();
        end

        // Unmapped space reads as FFFF and aliases nothing
        bus_write(16'h0000, 16'h1234, 2'b00);
        bus_write(16'h2000, 16'h9abc, 2'b00);
        bus_write(16'h4000, 16'h5678, 2'b00);
        bus_write(16'h0400, 16'hdead, 2'b00);
        bus_write(16'h2400, 16'hbeef, 2'b00);
        bus_write(16'h4100, 16'hcafe, 2'b00);
        bus_write(16'h6003, 16'h00ff, 2'b00);
        bus_write(16'ha000, 16'h0f0f, 2'b00);
        bus_read(16'h0400);
        bus_read(16'h2400);
        bus_read(16'h4100);
        bus_read(16'h6003);
        bus_read(16'ha000);
        bus_read(16'he123);
        bus_read(16'h0000);
        bus_read(16'h2000);
        bus_read(16'h4000);
        bus_read(16'h6000);
        wait_reads_done();

        // Control word
        st_addr = 8'h00;
        d = 16'(next_random());
        bus_write(16'h6000, d, 2'b00);
        idle_cycles(2);
        check_value("flip", flip, d[0]);
        check_value("video_en", video_en, d[1]);
        check_value("st_dout", st_dout, {4'd0, d[3:0]});
        bus_read(16'h6000);
        wait_reads_done();

        // Tile bank and scroll gating
        st_addr = 8'h01;
        d = {10'd0, 6'(next_random())};
        bus_write(16'h6001, d, 2'b00);
        idle_cycles(2);
        check_value("st_dout", st_dout, {2'd0, d[5:0]});
        bus_read(16'h6001);
        wait_reads_done();
        for (int k = 0; k < 2; k++) begin
            ve = (k == 0);
            bus_write(16'h6000, {14'd0, ve, 1'b0}, 2'b00);
            idle_cycles(2);
            a1        = 16'(next_random()) & 16'h7fff;
            a2        = 16'(next_random()) | 16'h8000;
            scr1_cs   = 1'b1;
            scr2_cs   = 1'b1;
            scr1_addr = a1;
            scr2_addr = a2;
            idle_cycles(1);
            check_value("scr1_adj", scr1_adj, {d[2:0], a1[14:0]});
            check_value("scr2_adj", scr2_adj, {d[5:3], a2[14:0]});
            check_value("scr1_cs_g", scr1_cs_g, ve);
            check_value("scr2_cs_g", scr2_cs_g, ve);
            scr1_cs = 1'b0;
            scr2_cs = 1'b0;
        end

        // Sound latch and interrupt handshake
        st_addr = 8'h02;
        d = 16'(next_random());
        bus_write(16'h6002, d, 2'b00);
        idle_cycles(2);
        check_value("snd_irqn", snd_irqn, 1'b0);
        check_value("st_dout", st_dout, d[7:0]);
        check_value("snd_latch", snd_latch, d[7:0]);
        bus_read(16'h6002);
        wait_reads_done();
        check_value("snd_irqn", snd_irqn, 1'b0);
        snd_ack = 1'b1;
        idle_cycles(1);
        snd_ack = 1'b0;
        wait_irq_release();

        // Undecoded status addresses read as zero
        st_addr = 8'h5a;
        idle_cycles(2);
        check_value("st_dout", st_dout, 8'h00);

        st_addr = 8'h03;
        idle_cycles(4);

        if (u_dut.u_sva.err_cnt != 0) begin
            fail_text("a concurrent assertion on the DUT failed");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== s16_game.f ====
source/s16_pkg.sv
source/s16_bus_decode.sv
source/s16_bus_exec.sv
source/s16_gfx_bank.sv
source/s16_result.sv
source/s16_game.sv
bench/s16_game_sva.sv
bench/s16_game_tb.sv

// ==== source/s16_bus_decode.sv ====
// CPU bus address decoder
`timescale 1ns/100ps
`default_nettype none

module s16_bus_decode #(
    parameter int CHAR_AW = 10,
    parameter int PAL_AW  = 10,
    parameter int OBJ_AW  = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  bus_stb,
    input  s16_pkg::s16_bus_req_t bus_req,
    output logic                  dec_vld,
    output s16_pkg::s16_dec_op_t  dec_op
);
    import s16_pkg::*;

    logic [12:0] local_ofs;
    s16_region_e region;

    // True when the offset lies inside a RAM of 2**aw words
    function automatic logic fits(input logic [12:0] ofs, input int aw);
        return (ofs >> aw) == 13'd0;
    endfunction

    assign local_ofs = bus_req.addr[12:0];

    always_comb begin
        region = REG_NONE;
        case (bus_req.addr[15:13])
            MAP_CHAR: begin
                if (fits(local_ofs, CHAR_AW)) begin
                    region = REG_CHAR;
                end
            end
            MAP_PAL: begin
                if (fits(local_ofs, PAL_AW)) begin
                    region = REG_PAL;
                end
            end
            MAP_OBJ: begin
                if (fits(local_ofs, OBJ_AW)) begin
                    region = REG_OBJ;
                end
            end
            MAP_IO: begin
                // Only the first three words of the block are decoded
                case (local_ofs)
                    IO_CTRL_OFS:  region = REG_IO_CTRL;
                    IO_BANK_OFS:  region = REG_IO_BANK;
                    IO_LATCH_OFS: region = REG_IO_LATCH;
                    default:      region = REG_NONE;
                endcase
            end
            default: region = REG_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_vld <= 1'b0;
        end else begin
            dec_vld <= bus_stb;
        end
    end

    // Operation fields follow the strobe
    always_ff @(posedge clk) begin
        if (bus_stb) begin
            dec_op.region <= region;
            dec_op.offset <= local_ofs[OFS_W-1:0];
            dec_op.data   <= bus_req.data;
            dec_op.be     <= ~bus_req.dsn;
            dec_op.rd     <= bus_req.rnw;
        end
    end

endmodule

`default_nettype wire

// ==== source/s16_bus_exec.sv ====
// Video RAMs and I/O registers
`timescale 1ns/100ps
`default_nettype none

module s16_bus_exec #(
    parameter int CHAR_AW = 10,
    parameter int PAL_AW  = 10,
    parameter int OBJ_AW  = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dec_vld,
    input  s16_pkg::s16_dec_op_t dec_op,
    input  logic                 snd_ack,
    output logic                 ex_vld,
    output s16_pkg::s16_rd_rsp_t ex_rsp,
    output s16_pkg::s16_ctrl_t   ctrl,
    output logic [5:0]           tile_bank,
    output logic [7:0]           snd_latch,
    output logic                 snd_irqn
);
    import s16_pkg::*;

    localparam int          RAM_AW  [3] = '{CHAR_AW, PAL_AW, OBJ_AW};
    localparam s16_region_e RAM_REG [3] = '{REG_CHAR, REG_PAL, REG_OBJ};

    s16_io_word_u io_w;
    logic         rd_hit;
    logic         wr_lo;
    logic [15:0]  ram_q [3];
    logic [15:0]  io_q;
    s16_region_e  rsp_region;

    assign io_w   = dec_op.data;
    assign rd_hit = dec_vld && dec_op.rd;
    // All I/O fields live in the low byte
    assign wr_lo  = dec_vld && !dec_op.rd && dec_op.be[0];

    // Character, palette and object RAM share one body
    for (genvar g = 0; g < 3; g++) begin : g_ram
        localparam int AW = RAM_AW[g];

        logic [15:0]   mem [2**AW];
        logic [15:0]   q;
        logic [AW-1:0] waddr;
        logic          hit;

        assign waddr = dec_op.offset[AW-1:0];
        assign hit   = dec_vld && dec_op.region == RAM_REG[g];

        always_ff @(posedge clk) begin
            if (hit) begin
                if (!dec_op.rd && dec_op.be[1]) begin
                    mem[waddr][15:8] <= dec_op.data[15:8];
                end
                if (!dec_op.rd && dec_op.be[0]) begin
                    mem[waddr][7:0] <= dec_op.data[7:0];
                end
                q <= mem[waddr];
            end
        end

        assign ram_q[g] = q;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl      <= '0;
            tile_bank <= '0;
            snd_latch <= '0;
            snd_irqn  <= 1'b1;
        end else begin
            if (wr_lo && dec_op.region == REG_IO_CTRL) begin
                ctrl.flip      <= io_w.ctrl.flip;
                ctrl.video_en  <= io_w.ctrl.video_en;
                ctrl.colscr_en <= io_w.ctrl.colscr_en;
                ctrl.rowscr_en <= io_w.ctrl.rowscr_en;
            end
            if (wr_lo && dec_op.region == REG_IO_BANK) begin
                tile_bank <= {io_w.bank.bank_hi, io_w.bank.bank_lo};
            end
            // A new latch value wins over a pending ack
            if (wr_lo && dec_op.region == REG_IO_LATCH) begin
                snd_latch <= dec_op.data[7:0];
                snd_irqn  <= 1'b0;
            end else if (snd_ack) begin
                snd_irqn <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_vld <= 1'b0;
        end else begin
            ex_vld <= rd_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hit) begin
            rsp_region <= dec_op.region;
            case (dec_op.region)
                REG_IO_CTRL:  io_q <= {12'd0, ctrl};
                REG_IO_BANK:  io_q <= {10'd0, tile_bank};
                REG_IO_LATCH: io_q <= {8'd0, snd_latch};
                default:      io_q <= '0;
            endcase
        end
    end

    always_comb begin
        ex_rsp.region = rsp_region;
        case (rsp_region)
            REG_CHAR: ex_rsp.data = ram_q[0];
            REG_PAL:  ex_rsp.data = ram_q[1];
            REG_OBJ:  ex_rsp.data = ram_q[2];
            default:  ex_rsp.data = io_q;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/s16_game.sv ====
// S16 main CPU bus top level
`timescale 1ns/100ps
`default_nettype none

module s16_game #(
    parameter int CHAR_AW = 10,
    parameter int PAL_AW  = 10,
    parameter int OBJ_AW  = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    // CPU bus
    input  logic                  bus_stb,
    input  s16_pkg::s16_bus_req_t bus_req,
    output logic                  rd_valid,
    output logic [15:0]           rd_data,
    // Sound CPU link
    input  logic                  snd_ack,
    output logic [7:0]            snd_latch,
    output logic                  snd_irqn,
    // Board video control
    output logic                  flip,
    output logic                  video_en,
    // Debug status
    input  logic [7:0]            st_addr,
    output logic [7:0]            st_dout,
    // Scroll ROM requests
    input  logic                  scr1_cs,
    input  logic                  scr2_cs,
    input  logic [15:0]           scr1_addr,
    input  logic [15:0]           scr2_addr,
    output logic                  scr1_cs_g,
    output logic                  scr2_cs_g,
    output logic [17:0]           scr1_adj,
    output logic [17:0]           scr2_adj
);
    import s16_pkg::*;

    logic        dec_vld;
    s16_dec_op_t dec_op;
    logic        ex_vld;
    s16_rd_rsp_t ex_rsp;
    s16_ctrl_t   ctrl;
    logic [5:0]  tile_bank;

    assign flip     = ctrl.flip;
    assign video_en = ctrl.video_en;

    s16_bus_decode #(
        .CHAR_AW ( CHAR_AW ),
        .PAL_AW  ( PAL_AW  ),
        .OBJ_AW  ( OBJ_AW  )
    ) u_decode (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .bus_stb ( bus_stb ),
        .bus_req ( bus_req ),
        .dec_vld ( dec_vld ),
        .dec_op  ( dec_op  )
    );

    s16_bus_exec #(
        .CHAR_AW ( CHAR_AW ),
        .PAL_AW  ( PAL_AW  ),
        .OBJ_AW  ( OBJ_AW  )
    ) u_exec (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .dec_vld   ( dec_vld   ),
        .dec_op    ( dec_op    ),
        .snd_ack   ( snd_ack   ),
        .ex_vld    ( ex_vld    ),
        .ex_rsp    ( ex_rsp    ),
        .ctrl      ( ctrl      ),
        .tile_bank ( tile_bank ),
        .snd_latch ( snd_latch ),
        .snd_irqn  ( snd_irqn  )
    );

    s16_result u_result (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .ex_vld    ( ex_vld    ),
        .ex_rsp    ( ex_rsp    ),
        .dec_vld   ( dec_vld   ),
        .ctrl      ( ctrl      ),
        .tile_bank ( tile_bank ),
        .snd_latch ( snd_latch ),
        .st_addr   ( st_addr   ),
        .rd_valid  ( rd_valid  ),
        .rd_data   ( rd_data   ),
        .st_dout   ( st_dout   )
    );

    // Scroll layers see the bank and the video enable as registered
    s16_gfx_bank u_gfx_bank (
        .clk       ( clk           ),
        .rst       ( rst           ),
        .video_en  ( ctrl.video_en ),
        .tile_bank ( tile_bank     ),
        .scr1_cs   ( scr1_cs       ),
        .scr2_cs   ( scr2_cs       ),
        .scr1_addr ( scr1_addr     ),
        .scr2_addr ( scr2_addr     ),
        .scr1_cs_g ( scr1_cs_g     ),
        .scr2_cs_g ( scr2_cs_g     ),
        .scr1_adj  ( scr1_adj      ),
        .scr2_adj  ( scr2_adj      )
    );

endmodule

`default_nettype wire

// ==== source/s16_gfx_bank.sv ====
// Scroll ROM tile banking
`timescale 1ns/100ps
`default_nettype none

module s16_gfx_bank (
    input  logic        clk,
    input  logic        rst,
    input  logic        video_en,
    input  logic [5:0]  tile_bank,
    input  logic        scr1_cs,
    input  logic        scr2_cs,
    input  logic [15:0] scr1_addr,
    input  logic [15:0] scr2_addr,
    output logic        scr1_cs_g,
    output logic        scr2_cs_g,
    output logic [17:0] scr1_adj,
    output logic [17:0] scr2_adj
);

    // Bit 15 picks the high or low bank, which replaces it on top
    function automatic logic [17:0] bank_addr(
        input logic [15:0] addr,
        input logic [5:0]  banks
    );
        logic [2:0] sel;
        sel = addr[15] ? banks[5:3] : banks[2:0];
        return {sel, addr[14:0]};
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            scr1_cs_g <= 1'b0;
            scr2_cs_g <= 1'b0;
        end else begin
            scr1_cs_g <= scr1_cs && video_en;
            scr2_cs_g <= scr2_cs && video_en;
        end
    end

    always_ff @(posedge clk) begin
        scr1_adj <= bank_addr(scr1_addr, tile_bank);
        scr2_adj <= bank_addr(scr2_addr, tile_bank);
    end

endmodule

`default_nettype wire

// ==== source/s16_pkg.sv ====
// S16 bus shared definitions
`default_nettype none

package s16_pkg;

    // Offset inside a region, wide enough for the largest RAM
    localparam int OFS_W = 10;

    // Region select, word address bits 15:13
    localparam logic [2:0] MAP_CHAR = 3'd0;
    localparam logic [2:0] MAP_PAL  = 3'd1;
    localparam logic [2:0] MAP_OBJ  = 3'd2;
    localparam logic [2:0] MAP_IO   = 3'd3;

    // Register offsets in the I/O block
    localparam int IO_CTRL_OFS  = 0;
    localparam int IO_BANK_OFS  = 1;
    localparam int IO_LATCH_OFS = 2;

    // Status port addresses
    localparam logic [7:0] ST_CTRL  = 8'h00;
    localparam logic [7:0] ST_BANK  = 8'h01;
    localparam logic [7:0] ST_LATCH = 8'h02;
    localparam logic [7:0] ST_COUNT = 8'h03;

    typedef enum logic [2:0] {
        REG_CHAR,
        REG_PAL,
        REG_OBJ,
        REG_IO_CTRL,
        REG_IO_BANK,
        REG_IO_LATCH,
        REG_NONE
    } s16_region_e;

    // One CPU access as it arrives with the strobe
    typedef struct packed {
        logic [15:0] addr;
        logic [15:0] data;
        logic [1:0]  dsn;
        logic        rnw;
    } s16_bus_req_t;

    typedef struct packed {
        s16_region_e      region;
        logic [OFS_W-1:0] offset;
        logic [15:0]      data;
        logic [1:0]       be;
        logic             rd;
    } s16_dec_op_t;

    // I/O data word, seen as control bits or as the two tile banks
    typedef union packed {
        struct packed {
            logic [11:0] unused;
            logic        rowscr_en;
            logic        colscr_en;
            logic        video_en;
            logic        flip;
        } ctrl;
        struct packed {
            logic [9:0] unused;
            logic [2:0] bank_hi;
            logic [2:0] bank_lo;
        } bank;
    } s16_io_word_u;

    typedef struct packed {
        logic rowscr_en;
        logic colscr_en;
        logic video_en;
        logic flip;
    } s16_ctrl_t;

    typedef struct packed {
        logic [15:0] data;
        s16_region_e region;
    } s16_rd_rsp_t;

endpackage

`default_nettype wire

// ==== source/s16_result.sv ====
// Read-back and status readout
`timescale 1ns/100ps
`default_nettype none

module s16_result (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ex_vld,
    input  s16_pkg::s16_rd_rsp_t ex_rsp,
    input  logic                 dec_vld,
    input  s16_pkg::s16_ctrl_t   ctrl,
    input  logic [5:0]           tile_bank,
    input  logic [7:0]           snd_latch,
    input  logic [7:0]           st_addr,
    output logic                 rd_valid,
    output logic [15:0]          rd_data,
    output logic [7:0]           st_dout
);
    import s16_pkg::*;

    logic [15:0] rd_mux;
    logic [7:0]  st_mux;
    logic [7:0]  acc_cnt;

    // Open bus reads back as all ones
    assign rd_mux = (ex_rsp.region == REG_NONE) ? 16'hffff : ex_rsp.data;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= ex_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_vld) begin
            rd_data <= rd_mux;
        end
    end

    // Every decoded access counts, wraps at 256
    always_ff @(posedge clk) begin
        if (rst) begin
            acc_cnt <= '0;
        end else if (dec_vld) begin
            acc_cnt <= acc_cnt + 8'd1;
        end
    end

    always_comb begin
        case (st_addr)
            ST_CTRL:  st_mux = {4'd0, ctrl};
            ST_BANK:  st_mux = {2'd0, tile_bank};
            ST_LATCH: st_mux = snd_latch;
            ST_COUNT: st_mux = acc_cnt;
            default:  st_mux = 8'h00;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st_dout <= '0;
        end else begin
            st_dout <= st_mux;
        end
    end

endmodule

`default_nettype wire
